/* filelist.f */
src/cpu_pkg.sv
src/program_ram.sv
src/fetcher.sv
src/executor.sv
src/tx_buffer.sv
src/uart_tx.sv
src/cpu_top.sv
verif/cpu_chk.sv
verif/cpu_tb.sv

/* Makefile */
# verilator build and run of the cpu testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run cpu_tb, check the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module cpu_tb -Mdir obj_dir -o cpu_sim
	./obj_dir/cpu_sim | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) && echo "PASS" || \
		(echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* program.mem */
// one 16-bit word per line, word 0 first; instruction pairs are {opcode, reg} then operand
// words outside the program hold F000 plus their own address
F000
F001
F002
F003
F004
F005
F006
F007
F008
F009
F00A
F00B
F00C
F00D
F00E
F00F
F010
F011
F012
F013
F014
F015
F016
F017
F018
F019
F01A
F01B
F01C
F01D
F01E
F01F
F020
F021
F022
F023
F024
F025
F026
F027
F028
F029
F02A
F02B
F02C
F02D
0402 // 46: num2reg r2
0041
0302 // 48: reg2ram r2 to word 10
000A
0402 // 50: num2reg r2
005A
0F02 // 52: int r2
0000
0203 // 54: ram2reg r3 from word 10
000A
0F03 // 56: int r3
0000
0900 // 58: unsupported opcode
0000
0100 // 60: jmp 46
002E
F03E
F03F

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

  localparam int frame_len = 10 * cpu_pkg::clks_per_bit;  // cycles per uart frame
  localparam int loop_len = 8;                             // bytes per pass of the program
  // three loops plus two start markers, 100 ns clock, 50 percent margin
  localparam longint watchdog_ns = longint'(3 * loop_len + 2) * frame_len * 100 * 3 / 2;

  logic clk;
  logic rst;
  logic tx;
  logic saw_full;  // buffer reached full at least once
  int   bytes_seen;

  cpu_top dut_i (
    .clk(clk),
    .rst(rst),
    .tx(tx)
  );

  always #50 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input cpu_pkg::byte_t got,
                            input cpu_pkg::byte_t expected);
    if (got !== expected) begin
      report_failure($sformatf("ERR %0t %s got 0x%h expected 0x%h",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_count(input string name, input int got, input int expected);
    if (got != expected) begin
      report_failure($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, expected));
    end
  endtask

  // one pass through the program, built from the trace rules
  function automatic cpu_pkg::byte_t loop_byte(input int idx);
    case (idx)
      0: return "C";    // num2reg r2
      1: return "N";    // reg2ram r2
      2: return "C";
      3: return 8'h5a;  // int r2 sends "Z"
      4: return "I";    // ram2reg r3
      5: return 8'h41;  // int r3, the "A" stored by reg2ram
      6: return "X";    // opcode 0x09
      default: return "J";
    endcase
  endfunction

  // falling clock edges, counting the ones where the transmitter is busy
  task automatic step_cycles(input int n, inout int busy_count);
    repeat (n) begin
      @(negedge clk);
      if (dut_i.busy) begin
        busy_count++;
      end
    end
  endtask

  // uart receiver model, samples each bit at its middle
  task automatic receive_byte(output cpu_pkg::byte_t value, output int frame_cycles);
    int busy_count;
    int bit_idx;
    busy_count = 0;
    @(negedge tx);
    step_cycles(cpu_pkg::clks_per_bit / 2, busy_count);
    if (tx !== 1'b0) begin
      report_failure($sformatf("framing error at %0t: start bit is not low", $time));
    end
    for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
      step_cycles(cpu_pkg::clks_per_bit, busy_count);
      value[bit_idx] = tx;  // lsb first
    end
    step_cycles(cpu_pkg::clks_per_bit, busy_count);
    if (tx !== 1'b1) begin
      report_failure($sformatf("framing error at %0t: stop bit is low", $time));
    end
    while (dut_i.busy) begin  // rest of the stop bit
      step_cycles(1, busy_count);
    end
    frame_cycles = busy_count;
    bytes_seen++;
  endtask

  task automatic expect_loop_bytes(input int first, input int count);
    cpu_pkg::byte_t value;
    int cycles;
    int idx;
    for (idx = first; idx < first + count; idx++) begin
      receive_byte(value, cycles);
      check_byte($sformatf("tx byte %0d", bytes_seen), value, loop_byte(idx));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic verify_start_marker();
    cpu_pkg::byte_t value;
    int cycles;
    receive_byte(value, cycles);
    check_byte("tx byte 1", value, "S");
    check_count("frame cycles", cycles, frame_len);
  endtask

  task automatic first_loop_trace();
    expect_loop_bytes(0, 4);  // C N C Z
  endtask

  task automatic ram_round_trip();
    expect_loop_bytes(4, 3);  // I A X
  endtask

  task automatic jump_and_repeat();
    expect_loop_bytes(7, 1);
    expect_loop_bytes(0, loop_len);  // back at word 46
  endtask

  task automatic back_pressure_loops();
    expect_loop_bytes(0, loop_len);
    if (!saw_full) begin
      report_failure("transmit buffer never filled, back-pressure not exercised");
    end
  endtask

  task automatic reset_mid_frame();
    cpu_pkg::byte_t value;
    int cycles;
    int busy_count;
    busy_count = 0;
    @(negedge tx);
    step_cycles(frame_len / 2, busy_count);  // halfway through a byte
    apply_reset();
    receive_byte(value, cycles);
    check_byte("tx byte after reset", value, "S");
    receive_byte(value, cycles);
    check_byte("tx byte after reset", value, "C");
  endtask

  always @(negedge clk) begin
    if (dut_i.buf_full === 1'b1) begin
      saw_full = 1'b1;
    end
    if (dut_i.chk_i.fail_count != 0) begin
      report_failure("a bound assertion in cpu_chk failed");
    end
  end

  initial begin
    #(watchdog_ns);
    report_failure($sformatf("timeout after %0d ns, the UART stream stalled", watchdog_ns));
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    saw_full = 1'b0;
    bytes_seen = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    verify_start_marker();
    first_loop_trace();
    ram_round_trip();
    jump_and_repeat();
    back_pressure_loops();
    reset_mid_frame();
    if (dut_i.chk_i.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_failure("a bound assertion in cpu_chk failed");
    end
  end

endmodule

/* verif/cpu_chk.sv */
`timescale 1ns/1ps

module cpu_chk (
  input logic clk,
  input logic rst,
  input logic pkt_valid,
  input logic exec_ready,
  input logic push,
  input logic buf_full,
  input logic tx,
  input logic start,
  input logic busy
);

  int fail_count = 0;  // read by the testbench

  a_handoff_ready: assert property (@(posedge clk) disable iff (rst) pkt_valid |-> exec_ready)
    else begin
      $error("pkt_valid raised while exec_ready is low");
      fail_count++;
    end

  a_push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !buf_full)
    else begin
      $error("push while the transmit buffer is full");
      fail_count++;
    end

  // line must idle high once reset has been seen
  a_tx_idle_in_reset: assert property (@(posedge clk) rst |=> tx)
    else begin
      $error("tx not high during reset");
      fail_count++;
    end

  a_start_when_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else begin
      $error("start raised while the transmitter is busy");
      fail_count++;
    end

endmodule

bind cpu_top cpu_chk chk_i (
  .clk(clk), .rst(rst), .pkt_valid(pkt_valid), .exec_ready(exec_ready),
  .push(push), .buf_full(buf_full), .tx(tx), .start(start), .busy(busy)
);

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic clk,
  input  logic rst,
  output logic tx
);

  cpu_pkg::addr_t      fetch_addr;
  cpu_pkg::word_t      fetch_data;
  cpu_pkg::fetch_pkt_t pkt;
  logic                pkt_valid;
  logic                exec_ready;
  logic                redirect;
  cpu_pkg::addr_t      redirect_addr;
  cpu_pkg::ram_req_t   req;
  logic                req_valid;
  cpu_pkg::word_t      rd_data;
  logic                push;
  cpu_pkg::byte_t      push_data;
  logic                buf_full;
  logic                start;
  cpu_pkg::byte_t      data;
  logic                busy;

  program_ram ram_i (
    .clk(clk), .fetch_addr(fetch_addr), .fetch_data(fetch_data),
    .req(req), .req_valid(req_valid), .rd_data(rd_data)
  );

  fetcher fetch_i (
    .clk(clk), .rst(rst), .fetch_addr(fetch_addr), .fetch_data(fetch_data),
    .pkt(pkt), .pkt_valid(pkt_valid), .exec_ready(exec_ready),
    .redirect(redirect), .redirect_addr(redirect_addr)
  );

  executor exec_i (
    .clk(clk), .rst(rst), .pkt(pkt), .pkt_valid(pkt_valid), .exec_ready(exec_ready),
    .redirect(redirect), .redirect_addr(redirect_addr), .req(req), .req_valid(req_valid),
    .rd_data(rd_data), .push(push), .push_data(push_data), .buf_full(buf_full)
  );

  tx_buffer buf_i (
    .clk(clk), .rst(rst), .push(push), .push_data(push_data), .buf_full(buf_full),
    .start(start), .data(data), .busy(busy)
  );

  uart_tx uart_i (
    .clk(clk), .rst(rst), .start(start), .data(data), .busy(busy), .tx(tx)
  );

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  cpu_pkg::byte_t data,
  output logic           busy,
  output logic           tx
);

  logic [8:0]                     shift;    // data bits then the stop bit
  logic [3:0]                     bit_cnt;  // 0 is the start bit, 9 the stop bit
  logic [cpu_pkg::baud_cnt_w-1:0] cyc_cnt;
  logic                           bit_end;

  assign bit_end = (cyc_cnt == cpu_pkg::baud_cnt_w'(cpu_pkg::clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      tx <= 1'b1;  // line idles high
      bit_cnt <= '0;
      cyc_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy <= 1'b1;
        tx <= 1'b0;  // start bit
        bit_cnt <= '0;
        cyc_cnt <= '0;
      end
    end else if (bit_end) begin
      cyc_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // stop bit done, tx already high
      end else begin
        tx <= shift[0];  // lsb first
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shift <= {1'b1, data};
    end else if (busy && bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

/* src/tx_buffer.sv */
`timescale 1ns/1ps

module tx_buffer (
  input  logic           clk,
  input  logic           rst,
  input  logic           push,
  input  cpu_pkg::byte_t push_data,
  output logic           buf_full,
  output logic           start,
  output cpu_pkg::byte_t data,
  input  logic           busy
);

  cpu_pkg::byte_t                mem [cpu_pkg::buf_depth];
  logic [cpu_pkg::buf_ptr_w-1:0] wr_ptr;
  logic [cpu_pkg::buf_ptr_w-1:0] rd_ptr;
  logic [cpu_pkg::buf_ptr_w:0]   count;  // one bit wider to tell full from empty

  assign buf_full = (count == cpu_pkg::buf_depth);
  assign start = (count != 0) && !busy;  // busy rises next cycle, so one-cycle strobe
  assign data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (start) begin
        rd_ptr <= rd_ptr + 1'b1;  // byte leaves with the strobe
      end
      case ({push, start})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

/* src/executor.sv */
`timescale 1ns/1ps

module executor (
  input  logic                clk,
  input  logic                rst,
  input  cpu_pkg::fetch_pkt_t pkt,
  input  logic                pkt_valid,
  output logic                exec_ready,
  output logic                redirect,
  output cpu_pkg::addr_t      redirect_addr,
  output cpu_pkg::ram_req_t   req,
  output logic                req_valid,
  input  cpu_pkg::word_t      rd_data,
  output logic                push,
  output cpu_pkg::byte_t      push_data,
  input  logic                buf_full
);

  cpu_pkg::word_t      regs [cpu_pkg::reg_count];
  cpu_pkg::fetch_pkt_t cur;        // instruction being executed
  cpu_pkg::byte_t      int_byte;   // register byte for int
  logic                busy;
  logic                second;     // second cycle of ram2reg or int
  logic                s_pending;  // start marker still owed after reset

  cpu_pkg::byte_t               opcode;
  logic [cpu_pkg::reg_idx_w-1:0] rsel;
  cpu_pkg::word_t               operand;
  cpu_pkg::byte_t               trace;
  logic                         two_cycle;
  logic                         finishing;
  logic                         done;

  assign opcode = cur.instr.opcode;
  assign rsel = cur.instr.reg_sel[cpu_pkg::reg_idx_w-1:0];
  assign operand = cur.instr.operand;

  assign two_cycle = (opcode == cpu_pkg::op_ram2reg) || (opcode == cpu_pkg::op_int);
  assign finishing = busy && (second || !two_cycle);
  // an instruction completes only in a cycle where its trace byte can go out
  assign done = finishing && !buf_full && !s_pending;
  assign exec_ready = !busy;

  always_comb begin
    case (opcode)
      cpu_pkg::op_num2reg: trace = cpu_pkg::trace_c;
      cpu_pkg::op_reg2ram: trace = cpu_pkg::trace_n;
      cpu_pkg::op_ram2reg: trace = cpu_pkg::trace_i;
      cpu_pkg::op_jmp: trace = cpu_pkg::trace_j;
      cpu_pkg::op_int: trace = int_byte;
      default: trace = cpu_pkg::trace_x;
    endcase
  end

  assign push = s_pending ? !buf_full : done;
  assign push_data = s_pending ? cpu_pkg::trace_s : trace;

  assign redirect = done && (opcode == cpu_pkg::op_jmp);
  assign redirect_addr = operand[cpu_pkg::addr_w-1:0];

  always_comb begin
    req.we = 1'b0;
    req.addr = operand[cpu_pkg::addr_w-1:0];
    req.wdata = regs[rsel];
    req_valid = 1'b0;
    if (busy && !second && opcode == cpu_pkg::op_ram2reg) begin
      req_valid = 1'b1;  // load, data back next cycle
    end
    if (done && opcode == cpu_pkg::op_reg2ram) begin
      req.we = 1'b1;
      req_valid = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      second <= 1'b0;
      s_pending <= 1'b1;
      for (int i = 0; i < cpu_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (s_pending && !buf_full) begin
        s_pending <= 1'b0;
      end
      if (pkt_valid) begin
        busy <= 1'b1;
        second <= 1'b0;
      end else if (done) begin
        busy <= 1'b0;
        second <= 1'b0;
      end else if (busy && two_cycle) begin
        second <= 1'b1;  // stays set while waiting on a full buffer
      end
      if (done && opcode == cpu_pkg::op_num2reg) begin
        regs[rsel] <= operand;
      end
      if (done && opcode == cpu_pkg::op_ram2reg) begin
        regs[rsel] <= rd_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pkt_valid) begin
      cur <= pkt;
    end
    if (busy && !second && opcode == cpu_pkg::op_int) begin
      int_byte <= regs[rsel][7:0];
    end
  end

endmodule

/* src/fetcher.sv */
`timescale 1ns/1ps

module fetcher (
  input  logic                clk,
  input  logic                rst,
  output cpu_pkg::addr_t      fetch_addr,
  input  cpu_pkg::word_t      fetch_data,
  output cpu_pkg::fetch_pkt_t pkt,
  output logic                pkt_valid,
  input  logic                exec_ready,
  input  logic                redirect,
  input  cpu_pkg::addr_t      redirect_addr
);

  typedef enum logic [1:0] {
    issue_lo,  // first word address on the bus
    take_lo,   // first word back, second address on the bus
    take_hi,   // second word back
    hold       // pair complete, waiting for the executor
  } fetch_state_t;

  fetch_state_t    state;
  cpu_pkg::addr_t  pc;     // address of the instruction being fetched or held
  cpu_pkg::instr_t instr;

  // a redirect puts the target on the bus in the same cycle
  always_comb begin
    if (redirect) begin
      fetch_addr = redirect_addr;
    end else if (state == take_lo) begin
      fetch_addr = pc + 1'b1;  // wraps at the end of memory
    end else begin
      fetch_addr = pc;
    end
  end

  assign pkt_valid = (state == hold) && exec_ready;
  assign pkt.pc = pc;
  assign pkt.instr = instr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= issue_lo;
      pc <= cpu_pkg::program_start;
    end else if (redirect) begin
      pc <= redirect_addr;
      state <= take_lo;  // drops whatever was held or in flight
    end else begin
      case (state)
        issue_lo: state <= take_lo;
        take_lo: state <= take_hi;
        take_hi: state <= hold;
        default: begin
          if (exec_ready) begin  // handed off this cycle
            pc <= pc + 2'd2;
            state <= issue_lo;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == take_lo) begin
      {instr.opcode, instr.reg_sel} <= fetch_data;
    end
    if (state == take_hi) begin
      instr.operand <= fetch_data;
    end
  end

endmodule

/* src/program_ram.sv */
`timescale 1ns/1ps

module program_ram (
  input  logic              clk,
  input  cpu_pkg::addr_t    fetch_addr,
  output cpu_pkg::word_t    fetch_data,
  input  cpu_pkg::ram_req_t req,
  input  logic              req_valid,
  output cpu_pkg::word_t    rd_data
);

  cpu_pkg::word_t mem [cpu_pkg::ram_words];

  initial begin
    $readmemh("program.mem", mem);
  end

  // fetch port reads every cycle
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

  // executor port, read data holds until the next request
  always_ff @(posedge clk) begin
    if (req_valid) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end
      rd_data <= mem[req.addr];  // old data on a write
    end
  end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

  // memory and datapath sizes
  localparam int addr_w = 6;
  localparam int word_w = 16;
  localparam int ram_words = 64;
  localparam int reg_count = 32;
  localparam int reg_idx_w = $clog2(reg_count);

  localparam int buf_depth = 16;
  localparam int buf_ptr_w = $clog2(buf_depth);

  localparam int clks_per_bit = 16;  // 868 for 115200 baud at 100 MHz
  localparam int baud_cnt_w = $clog2(clks_per_bit);

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [word_w-1:0] word_t;
  typedef logic [7:0] byte_t;

  localparam addr_t program_start = 6'd46;  // first word after the process header area

  // opcodes, upper byte of the first instruction word
  localparam byte_t op_jmp = 8'h01;
  localparam byte_t op_ram2reg = 8'h02;
  localparam byte_t op_reg2ram = 8'h03;
  localparam byte_t op_num2reg = 8'h04;
  localparam byte_t op_int = 8'h0F;  // register low byte out to the uart

  // trace characters
  localparam byte_t trace_s = "S";
  localparam byte_t trace_c = "C";
  localparam byte_t trace_n = "N";
  localparam byte_t trace_i = "I";
  localparam byte_t trace_j = "J";
  localparam byte_t trace_x = "X";

  typedef struct packed {
    byte_t opcode;   // first word, high byte
    byte_t reg_sel;  // first word, low byte
    word_t operand;  // second word
  } instr_t;

  typedef struct packed {
    addr_t  pc;
    instr_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } ram_req_t;

endpackage
